/* common/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Bus widths of the register block port
`define UART_AW 3
`define UART_DW 8

// Addresses 0 and 1 are banked by the DLAB bit
`define UART_REG_DL1 3'd0
`define UART_REG_DL2 3'd1
`define UART_REG_IE  3'd1
`define UART_REG_FC  3'd2
`define UART_REG_LC  3'd3

// Divisor written during bring-up
`define UART_DIVISOR_LO 8'h1b
`define UART_DIVISOR_HI 8'h00

// 8 data bits, 1 stop bit, no parity
`define UART_LC_RESET 8'h03

`define UART_LC_DLAB 8'h80
`define UART_IE_RDA  8'h01

`endif

/* common/wb_pkg.sv */
package wb_pkg;

	// Direction of a single bus access
	typedef enum logic {
		WB_READ  = 1'b0,
		WB_WRITE = 1'b1
	} wb_op_e;

	// Current owner of the shared register bus
	typedef enum logic [1:0] {
		GRANT_NONE = 2'd0,
		GRANT_CFG  = 2'd1,
		GRANT_HOST = 2'd2
	} wb_grant_e;

endpackage

/* common/uart_cfg_pkg.sv */
package uart_cfg_pkg;

	// Each access has an issue state and a wait-ack state
	typedef enum logic [4:0] {
		CFG_IDLE,
		CFG_RD_LC0,
		CFG_RD_LC0_ACK,
		CFG_WR_LC_DLAB,
		CFG_WR_LC_DLAB_ACK,
		CFG_WR_DL2,
		CFG_WR_DL2_ACK,
		CFG_WR_DL1,
		CFG_WR_DL1_ACK,
		CFG_RD_LC1,
		CFG_RD_LC1_ACK,
		CFG_WR_LC,
		CFG_WR_LC_ACK,
		CFG_WR_FC,
		CFG_WR_FC_ACK,
		CFG_RD_IE,
		CFG_RD_IE_ACK,
		CFG_WR_IE,
		CFG_WR_IE_ACK,
		CFG_GAP,
		CFG_DONE
	} cfg_state_e;

endpackage

/* common/wb_if.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

interface wb_if;

	logic                cyc;
	logic                stb;
	logic                we;
	logic [`UART_AW-1:0] addr;
	logic [`UART_DW-1:0] wdata;
	logic [`UART_DW-1:0] rdata;
	logic                ack;

	modport master (
		output cyc, stb, we, addr, wdata,
		input  rdata, ack
	);

	modport slave (
		input  cyc, stb, we, addr, wdata,
		output rdata, ack
	);

	modport monitor (
		input cyc, stb, we, addr, wdata, rdata, ack
	);

endinterface

/* hw/uart_config.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_config import wb_pkg::*, uart_cfg_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  logic start_config_i,
	output logic config_done_o,
	wb_if.master bus
);

	cfg_state_e          state_q;
	cfg_state_e          state_d;
	cfg_state_e          ret_q;
	cfg_state_e          ret_d;
	cfg_state_e          follow;
	logic                wait_ack;
	logic [`UART_DW-1:0] mod_q;
	wb_op_e              op;
	logic                cyc;
	logic [`UART_AW-1:0] addr;
	logic [`UART_DW-1:0] wdata;

	// The issue and wait-ack state of a step drive the same access
	always_comb begin
		op = WB_READ;
		cyc = 1'b0;
		addr = '0;
		wdata = '0;
		case (state_q)
			CFG_RD_LC0, CFG_RD_LC0_ACK, CFG_RD_LC1, CFG_RD_LC1_ACK: begin
				cyc = 1'b1;
				addr = `UART_REG_LC;
			end
			CFG_WR_LC_DLAB, CFG_WR_LC_DLAB_ACK: begin
				cyc = 1'b1;
				op = WB_WRITE;
				addr = `UART_REG_LC;
				wdata = mod_q | `UART_LC_DLAB;
			end
			CFG_WR_DL2, CFG_WR_DL2_ACK: begin
				cyc = 1'b1;
				op = WB_WRITE;
				addr = `UART_REG_DL2;
				wdata = `UART_DIVISOR_HI;
			end
			CFG_WR_DL1, CFG_WR_DL1_ACK: begin
				cyc = 1'b1;
				op = WB_WRITE;
				addr = `UART_REG_DL1;
				wdata = `UART_DIVISOR_LO;
			end
			CFG_WR_LC, CFG_WR_LC_ACK: begin
				cyc = 1'b1;
				op = WB_WRITE;
				addr = `UART_REG_LC;
				wdata = mod_q & ~`UART_LC_DLAB;
			end
			CFG_WR_FC, CFG_WR_FC_ACK: begin
				cyc = 1'b1;
				op = WB_WRITE;
				addr = `UART_REG_FC;
			end
			CFG_RD_IE, CFG_RD_IE_ACK: begin
				cyc = 1'b1;
				addr = `UART_REG_IE;
			end
			CFG_WR_IE, CFG_WR_IE_ACK: begin
				cyc = 1'b1;
				op = WB_WRITE;
				addr = `UART_REG_IE;
				wdata = mod_q | `UART_IE_RDA;
			end
			default: ;
		endcase
	end

	always_comb begin
		state_d = state_q;
		ret_d = ret_q;
		follow = CFG_DONE;
		wait_ack = 1'b0;
		case (state_q)
			CFG_IDLE: if (start_config_i) state_d = CFG_RD_LC0;
			CFG_RD_LC0: state_d = CFG_RD_LC0_ACK;
			CFG_WR_LC_DLAB: state_d = CFG_WR_LC_DLAB_ACK;
			CFG_WR_DL2: state_d = CFG_WR_DL2_ACK;
			CFG_WR_DL1: state_d = CFG_WR_DL1_ACK;
			CFG_RD_LC1: state_d = CFG_RD_LC1_ACK;
			CFG_WR_LC: state_d = CFG_WR_LC_ACK;
			CFG_WR_FC: state_d = CFG_WR_FC_ACK;
			CFG_RD_IE: state_d = CFG_RD_IE_ACK;
			CFG_WR_IE: state_d = CFG_WR_IE_ACK;
			CFG_RD_LC0_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_WR_LC_DLAB;
			end
			CFG_WR_LC_DLAB_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_WR_DL2;
			end
			CFG_WR_DL2_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_WR_DL1;
			end
			CFG_WR_DL1_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_RD_LC1;
			end
			CFG_RD_LC1_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_WR_LC;
			end
			CFG_WR_LC_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_WR_FC;
			end
			CFG_WR_FC_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_RD_IE;
			end
			CFG_RD_IE_ACK: begin
				wait_ack = 1'b1;
				follow = CFG_WR_IE;
			end
			CFG_WR_IE_ACK: wait_ack = 1'b1;
			CFG_GAP: state_d = ret_q;
			default: ;
		endcase
		// Bus is released for one cycle before the next step, except after the last one
		if (wait_ack && bus.ack) begin
			state_d = (follow == CFG_DONE) ? CFG_DONE : CFG_GAP;
			ret_d = follow;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= CFG_IDLE;
			ret_q <= CFG_IDLE;
		end else begin
			state_q <= state_d;
			ret_q <= ret_d;
		end
	end

	// Read data feeds the modify step of the next write
	always_ff @(posedge clk) begin
		if (bus.ack && op == WB_READ)
			mod_q <= bus.rdata;
	end

	assign bus.cyc = cyc;
	assign bus.stb = cyc;
	assign bus.we = (op == WB_WRITE);
	assign bus.addr = addr;
	assign bus.wdata = wdata;

	assign config_done_o = (state_q == CFG_DONE);

endmodule

/* hw/host_bus_port.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module host_bus_port import wb_pkg::*; (
	input  logic                clk,
	input  logic                rstn,
	input  logic                req_i,
	input  logic                we_i,
	input  logic [`UART_AW-1:0] addr_i,
	input  logic [`UART_DW-1:0] wdata_i,
	output logic                busy_o,
	output logic                done_o,
	output logic [`UART_DW-1:0] rdata_o,
	wb_if.master                bus
);

	wb_op_e              op_q;
	logic [`UART_AW-1:0] addr_q;
	logic [`UART_DW-1:0] wdata_q;
	logic [`UART_DW-1:0] rdata_q;
	logic                cyc_q;
	logic                busy_q;
	logic                done_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cyc_q <= 1'b0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
			rdata_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (req_i && !busy_q) begin
				cyc_q <= 1'b1;
				busy_q <= 1'b1;
			end else if (cyc_q && bus.ack) begin
				cyc_q <= 1'b0;
				done_q <= 1'b1;
				if (op_q == WB_READ)
					rdata_q <= bus.rdata;
			end else if (done_q) begin
				busy_q <= 1'b0;
			end
		end
	end

	// Request fields are held for the whole transaction
	always_ff @(posedge clk) begin
		if (req_i && !busy_q) begin
			op_q <= we_i ? WB_WRITE : WB_READ;
			addr_q <= addr_i;
			wdata_q <= wdata_i;
		end
	end

	assign bus.cyc = cyc_q;
	assign bus.stb = cyc_q;
	assign bus.we = (op_q == WB_WRITE);
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;

	assign busy_o = busy_q;
	assign done_o = done_q;
	assign rdata_o = rdata_q;

endmodule

/* hw/wb_arbiter.sv */
`timescale 1ns/10ps

module wb_arbiter import wb_pkg::*; (
	input  logic      clk,
	input  logic      rstn,
	wb_if.slave       m0,
	wb_if.slave       m1,
	wb_if.master      s,
	output wb_grant_e grant_o
);

	wb_grant_e grant_q;
	wb_grant_e grant_d;
	wb_grant_e pick;

	// Sequencer wins a tie on a free bus
	assign pick = m0.cyc ? GRANT_CFG : (m1.cyc ? GRANT_HOST : GRANT_NONE);

	always_comb begin
		grant_d = grant_q;
		case (grant_q)
			GRANT_CFG: if (!m0.cyc) grant_d = pick;
			GRANT_HOST: if (!m1.cyc) grant_d = pick;
			default: grant_d = pick;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			grant_q <= GRANT_NONE;
		else
			grant_q <= grant_d;
	end

	always_comb begin
		s.cyc = 1'b0;
		s.stb = 1'b0;
		s.we = 1'b0;
		s.addr = '0;
		s.wdata = '0;
		m0.ack = 1'b0;
		m0.rdata = '0;
		m1.ack = 1'b0;
		m1.rdata = '0;
		case (grant_q)
			GRANT_CFG: begin
				s.cyc = m0.cyc;
				s.stb = m0.stb;
				s.we = m0.we;
				s.addr = m0.addr;
				s.wdata = m0.wdata;
				m0.ack = s.ack;
				m0.rdata = s.rdata;
			end
			GRANT_HOST: begin
				s.cyc = m1.cyc;
				s.stb = m1.stb;
				s.we = m1.we;
				s.addr = m1.addr;
				s.wdata = m1.wdata;
				m1.ack = s.ack;
				m1.rdata = s.rdata;
			end
			default: ;
		endcase
	end

	assign grant_o = grant_q;

endmodule

/* uart_regs/uart_regs.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_regs (
	input  logic                  clk,
	input  logic                  rstn,
	wb_if.slave                   bus,
	output logic [2*`UART_DW-1:0] divisor_o,
	output logic [`UART_DW-1:0]   line_ctrl_o,
	output logic [`UART_DW-1:0]   int_en_o
);

	logic [`UART_DW-1:0] lc_q;
	logic [`UART_DW-1:0] dl1_q;
	logic [`UART_DW-1:0] dl2_q;
	logic [`UART_DW-1:0] ie_q;
	logic [`UART_DW-1:0] fc_q;
	logic [`UART_DW-1:0] rd_mux;
	logic [`UART_DW-1:0] rdata_q;
	logic                ack_q;
	logic                req;
	logic                dlab;

	assign req = bus.cyc && bus.stb && !ack_q;
	assign dlab = |(lc_q & `UART_LC_DLAB);

	// Address 0 without DLAB is the data port, which lives outside this block
	always_comb begin
		rd_mux = '0;
		case (bus.addr)
			`UART_REG_DL1: rd_mux = dlab ? dl1_q : '0;
			`UART_REG_IE: rd_mux = dlab ? dl2_q : ie_q;
			`UART_REG_FC: rd_mux = fc_q;
			`UART_REG_LC: rd_mux = lc_q;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			lc_q <= `UART_LC_RESET;
			dl1_q <= '0;
			dl2_q <= '0;
			ie_q <= '0;
			fc_q <= '0;
		end else begin
			ack_q <= req;
			if (req && bus.we) begin
				case (bus.addr)
					`UART_REG_DL1: if (dlab) dl1_q <= bus.wdata;
					`UART_REG_IE: begin
						if (dlab)
							dl2_q <= bus.wdata;
						else
							ie_q <= bus.wdata;
					end
					`UART_REG_FC: fc_q <= bus.wdata;
					`UART_REG_LC: lc_q <= bus.wdata;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			rdata_q <= rd_mux;
	end

	assign bus.ack = ack_q;
	assign bus.rdata = rdata_q;

	assign divisor_o = {dl2_q, dl1_q};
	assign line_ctrl_o = lc_q;
	assign int_en_o = ie_q;

endmodule

/* hw/uart_cfg_top.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_cfg_top import wb_pkg::*; (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  start_config_i,
	output logic                  config_done_o,
	input  logic                  host_req_i,
	input  logic                  host_we_i,
	input  logic [`UART_AW-1:0]   host_addr_i,
	input  logic [`UART_DW-1:0]   host_wdata_i,
	output logic                  host_busy_o,
	output logic                  host_done_o,
	output logic [`UART_DW-1:0]   host_rdata_o,
	output logic [2*`UART_DW-1:0] divisor_o,
	output logic [`UART_DW-1:0]   line_ctrl_o,
	output logic [`UART_DW-1:0]   int_en_o
);

	wb_grant_e grant;

	wb_if cfg_bus ();
	wb_if host_bus ();
	wb_if reg_bus ();

	uart_config u_config (
		.clk            (clk),
		.rstn           (rstn),
		.start_config_i (start_config_i),
		.config_done_o  (config_done_o),
		.bus            (cfg_bus.master)
	);

	host_bus_port u_host (
		.clk     (clk),
		.rstn    (rstn),
		.req_i   (host_req_i),
		.we_i    (host_we_i),
		.addr_i  (host_addr_i),
		.wdata_i (host_wdata_i),
		.busy_o  (host_busy_o),
		.done_o  (host_done_o),
		.rdata_o (host_rdata_o),
		.bus     (host_bus.master)
	);

	// Port m0 carries the sequencer, which has priority
	wb_arbiter u_arbiter (
		.clk     (clk),
		.rstn    (rstn),
		.m0      (cfg_bus.slave),
		.m1      (host_bus.slave),
		.s       (reg_bus.master),
		.grant_o (grant)
	);

	uart_regs u_regs (
		.clk         (clk),
		.rstn        (rstn),
		.bus         (reg_bus.slave),
		.divisor_o   (divisor_o),
		.line_ctrl_o (line_ctrl_o),
		.int_en_o    (int_en_o)
	);

endmodule

/* verification/uart_cfg_tb.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_cfg_tb;

	localparam int N_CONT = 20;
	localparam int N_RAND = 250;
	// Three bring-ups, two setup writes, contention reads and random accesses
	localparam int N_ACC = 3 * 9 + 2 + N_CONT + N_RAND;
	localparam int TIMEOUT = N_ACC * 20 + 4000;

	logic        clk;
	logic        rstn;
	logic        start_config_i;
	logic        config_done_o;
	logic        host_req_i;
	logic        host_we_i;
	logic [2:0]  host_addr_i;
	logic [7:0]  host_wdata_i;
	logic        host_busy_o;
	logic        host_done_o;
	logic [7:0]  host_rdata_o;
	logic [15:0] divisor_o;
	logic [7:0]  line_ctrl_o;
	logic [7:0]  int_en_o;

	integer      seed = 89677;
	logic [31:0] rnd;
	int          cycles = 0;
	int          errors = 0;
	int          checks = 0;
	string       phase = "reset";

	// Register model and bookkeeping of the sequencer
	logic [7:0]  m_lc;
	logic [7:0]  m_dl1;
	logic [7:0]  m_dl2;
	logic [7:0]  m_ie;
	logic [7:0]  m_fc;
	logic [7:0]  m_mod;
	logic [7:0]  m_lc_start;
	logic [7:0]  m_ie_start;
	int          seq_steps;
	logic        cfg_seen;
	logic        cfg_started;
	logic        rst_seen;

	logic        pend_we;
	logic [2:0]  pend_addr;
	logic [7:0]  pend_wdata;
	logic        poking = 1'b0;

	uart_cfg_top uut (
		.clk            (clk),
		.rstn           (rstn),
		.start_config_i (start_config_i),
		.config_done_o  (config_done_o),
		.host_req_i     (host_req_i),
		.host_we_i      (host_we_i),
		.host_addr_i    (host_addr_i),
		.host_wdata_i   (host_wdata_i),
		.host_busy_o    (host_busy_o),
		.host_done_o    (host_done_o),
		.host_rdata_o   (host_rdata_o),
		.divisor_o      (divisor_o),
		.line_ctrl_o    (line_ctrl_o),
		.int_en_o       (int_en_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Addresses 0 and 1 are banked by DLAB and address 0 reads zero without it
	function automatic logic [7:0] model_access(input logic we, input logic [2:0] addr,
			input logic [7:0] wdata);
		logic       dlab;
		logic [7:0] rd;
		dlab = (m_lc & `UART_LC_DLAB) != 8'h00;
		rd = 8'h00;
		case (addr)
			`UART_REG_DL1: begin
				rd = dlab ? m_dl1 : 8'h00;
				if (we && dlab)
					m_dl1 = wdata;
			end
			`UART_REG_IE: begin
				rd = dlab ? m_dl2 : m_ie;
				if (we && dlab)
					m_dl2 = wdata;
				else if (we)
					m_ie = wdata;
			end
			`UART_REG_FC: begin
				rd = m_fc;
				if (we)
					m_fc = wdata;
			end
			`UART_REG_LC: begin
				rd = m_lc;
				if (we)
					m_lc = wdata;
			end
			default: rd = 8'h00;
		endcase
		return rd;
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic model_seq_step();
		case (seq_steps)
			0: m_mod = model_access(1'b0, `UART_REG_LC, 8'h00);
			1: void'(model_access(1'b1, `UART_REG_LC, m_mod | `UART_LC_DLAB));
			2: void'(model_access(1'b1, `UART_REG_DL2, `UART_DIVISOR_HI));
			3: void'(model_access(1'b1, `UART_REG_DL1, `UART_DIVISOR_LO));
			4: m_mod = model_access(1'b0, `UART_REG_LC, 8'h00);
			5: void'(model_access(1'b1, `UART_REG_LC, m_mod & ~`UART_LC_DLAB));
			6: void'(model_access(1'b1, `UART_REG_FC, 8'h00));
			7: m_mod = model_access(1'b0, `UART_REG_IE, 8'h00);
			8: void'(model_access(1'b1, `UART_REG_IE, m_mod | `UART_IE_RDA));
			default: begin
				errors++;
				$display("The sequencer made a bus access beyond its nine steps");
			end
		endcase
		seq_steps++;
	endtask

	task automatic check_config();
		check_value({phase, " divisor"}, {`UART_DIVISOR_HI, `UART_DIVISOR_LO}, divisor_o);
		check_value({phase, " divisor model"}, {m_dl2, m_dl1}, divisor_o);
		check_value({phase, " line ctrl"}, {8'h00, m_lc_start & ~`UART_LC_DLAB},
			{8'h00, line_ctrl_o});
		check_value({phase, " line ctrl model"}, {8'h00, m_lc}, {8'h00, line_ctrl_o});
		check_value({phase, " int enable"}, {8'h00, m_ie_start | `UART_IE_RDA},
			{8'h00, int_en_o});
		check_value({phase, " int enable model"}, {8'h00, m_ie}, {8'h00, int_en_o});
		check_value({phase, " sequencer accesses"}, 16'd9, seq_steps[15:0]);
	endtask

	task automatic check_host();
		logic [7:0] exp;
		exp = model_access(pend_we, pend_addr, pend_wdata);
		if (!pend_we)
			check_value($sformatf("%s read addr %0d", phase, pend_addr), {8'h00, exp},
				{8'h00, host_rdata_o});
		check_value({phase, " line ctrl after host access"}, {8'h00, m_lc},
			{8'h00, line_ctrl_o});
	endtask

	// Outputs are sampled mid-cycle, well away from both clock edges
	always @(negedge clk) begin
		if (!rstn) begin
			m_lc = `UART_LC_RESET;
			m_dl1 = 8'h00;
			m_dl2 = 8'h00;
			m_ie = 8'h00;
			m_fc = 8'h00;
			seq_steps = 0;
			cfg_seen = 1'b0;
			cfg_started = 1'b0;
			rst_seen = 1'b1;
		end else begin
			if (rst_seen) begin
				rst_seen = 1'b0;
				check_value("reset config done", 16'd0, {15'd0, config_done_o});
				check_value("reset host busy", 16'd0, {15'd0, host_busy_o});
				check_value("reset host done", 16'd0, {15'd0, host_done_o});
				check_value("reset line ctrl", {8'h00, `UART_LC_RESET}, {8'h00, line_ctrl_o});
				check_value("reset divisor", 16'd0, divisor_o);
				check_value("reset int enable", 16'd0, {8'h00, int_en_o});
			end
			if (start_config_i && !cfg_started) begin
				cfg_started = 1'b1;
				m_lc_start = m_lc;
				m_ie_start = m_ie;
			end
			if (poking)
				check_value({phase, " busy during ignored request"}, 16'd1,
					{15'd0, host_busy_o});
			if (uut.cfg_bus.ack)
				model_seq_step();
			if (host_done_o)
				check_host();
			if (config_done_o && !cfg_seen) begin
				cfg_seen = 1'b1;
				check_config();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		#5;
		rstn = 1'b0;
		start_config_i = 1'b0;
		host_req_i = 1'b0;
		repeat (4) @(posedge clk);
		#5;
		rstn = 1'b1;
	endtask

	task automatic start_config();
		@(posedge clk);
		#5;
		start_config_i = 1'b1;
	endtask

	task automatic wait_config();
		@(negedge clk);
		while (!config_done_o)
			@(negedge clk);
	endtask

	// A second request while busy must be dropped by the port
	task automatic host_access(input logic we, input logic [2:0] addr, input logic [7:0] wdata,
			input logic poke);
		logic [31:0] junk;
		@(posedge clk);
		#5;
		pend_we = we;
		pend_addr = addr;
		pend_wdata = wdata;
		host_req_i = 1'b1;
		host_we_i = we;
		host_addr_i = addr;
		host_wdata_i = wdata;
		@(posedge clk);
		#5;
		host_req_i = 1'b0;
		if (poke) begin
			@(posedge clk);
			#5;
			junk = $random(seed);
			poking = 1'b1;
			host_req_i = 1'b1;
			host_we_i = 1'b1;
			host_addr_i = junk[2:0];
			host_wdata_i = junk[15:8];
			@(posedge clk);
			#5;
			poking = 1'b0;
			host_req_i = 1'b0;
		end
		@(negedge clk);
		while (!host_done_o)
			@(negedge clk);
	endtask

	initial begin
		rstn = 1'b0;
		start_config_i = 1'b0;
		host_req_i = 1'b0;
		host_we_i = 1'b0;
		host_addr_i = 3'd0;
		host_wdata_i = 8'h00;

		phase = "start only";
		apply_reset();
		start_config();
		wait_config();

		phase = "rmw keep";
		apply_reset();
		rnd = $random(seed);
		host_access(1'b1, `UART_REG_IE, rnd[7:0] & ~`UART_IE_RDA, 1'b0);
		host_access(1'b1, `UART_REG_LC, rnd[15:8] & ~`UART_LC_DLAB, 1'b0);
		start_config();
		wait_config();

		phase = "contention";
		apply_reset();
		fork
			start_config();
			begin
				for (int i = 0; i < N_CONT; i++) begin
					rnd = $random(seed);
					host_access(1'b0, rnd[2:0], 8'h00, 1'b0);
				end
			end
		join
		wait_config();

		phase = "random";
		for (int i = 0; i < N_RAND; i++) begin
			rnd = $random(seed);
			host_access(rnd[0], rnd[3:1], rnd[15:8], rnd[6:4] == 3'd0);
		end

		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/wb_pkg.sv
common/uart_cfg_pkg.sv
common/wb_if.sv
hw/uart_config.sv
hw/host_bus_port.sv
hw/wb_arbiter.sv
uart_regs/uart_regs.sv
hw/uart_cfg_top.sv
verification/uart_cfg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module uart_cfg_tb -Mdir obj_dir -f vlog.f \
	&& ./obj_dir/Vuart_cfg_tb | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
